//--- include/lstm_config.svh
/*
  Size settings for the LSTM cell engine.
  Included by the package and by any module that sizes arrays or constants.
*/
`ifndef LSTM_CONFIG_SVH
`define LSTM_CONFIG_SVH

////////////////////
// network shape
////////////////////

`define LSTM_NEURONS 8 // hidden neurons per step

////////////////////
// number format
////////////////////

// signed Q4.4 everywhere
`define LSTM_DATA_WIDTH 8
`define LSTM_FRAC_BITS 4

////////////////////
// input word memory
////////////////////

`define LSTM_X_DEPTH 128
`define LSTM_ADDR_WIDTH 7 // log2 of the x depth

`endif

//--- logic/lstm_pkg.sv
/*
  Shared types of the LSTM cell engine.
  Modules import it inside their body and use scoped names in port lists.
*/
`default_nettype none

package lstm_pkg;

  `include "lstm_config.svh"

  typedef logic signed [`LSTM_DATA_WIDTH-1:0] data_t; // Q4.4
  typedef logic [$clog2(`LSTM_NEURONS)-1:0] neuron_idx_t;
  typedef logic [`LSTM_ADDR_WIDTH-1:0] step_addr_t; // x address, doubles as step tag

  // diagonal weights of one gate
  typedef struct packed {
    data_t wx;
    data_t uh;
    data_t bias;
  } gate_weights_t;

  typedef struct packed {
    gate_weights_t gate_i;
    gate_weights_t gate_f;
    gate_weights_t gate_o;
    gate_weights_t gate_g; // candidate
  } neuron_params_t;

  ////////////////////
  // load ports
  ////////////////////

  typedef struct packed {
    logic       en;
    step_addr_t addr;
    data_t      data;
  } x_write_t;

  typedef struct packed {
    logic           en;
    neuron_idx_t    neuron;
    neuron_params_t params;
  } param_write_t;

  ////////////////////
  // pipeline bundles
  ////////////////////

  typedef struct packed {
    neuron_idx_t    neuron;
    step_addr_t     step;
    data_t          x;
    neuron_params_t params;
    data_t          c_prev;
    data_t          h_prev;
  } neuron_req_t;

  typedef struct packed {
    neuron_idx_t neuron;
    step_addr_t  step;
    data_t       c_new;
    data_t       h;
  } neuron_result_t;

  typedef struct packed {
    step_addr_t  step;
    neuron_idx_t neuron;
    data_t       h;
  } h_out_t;

endpackage

`default_nettype wire

//--- logic/sync_ram.sv
/*
  Single-port style synchronous RAM, separate write and read address.
  Read data appears one cycle after the read address.
*/
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16
) (
  input  wire                      clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  payload_t                 wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output payload_t                 rdata
);

  payload_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, old data on a same-address write
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

//--- logic/step_sequencer.sv
/*
  Walks the x memory from start_addr to end_addr and issues every neuron once per step.
  A step closes only after all its results are back, so the state reads never race.
*/
`timescale 1ns/1ps
`default_nettype none
`include "lstm_config.svh"

module step_sequencer (
  input  wire                     clk,
  input  wire                     arst_n,
  input  logic                    start,
  input  lstm_pkg::step_addr_t    start_addr,
  input  lstm_pkg::step_addr_t    end_addr,
  output lstm_pkg::step_addr_t    x_addr,
  output lstm_pkg::neuron_idx_t   param_addr,
  input  lstm_pkg::data_t         x,
  input  lstm_pkg::neuron_params_t params,
  input  lstm_pkg::data_t         c_prev,
  input  lstm_pkg::data_t         h_prev,
  output logic                    req_valid,
  input  logic                    req_ready,
  output lstm_pkg::neuron_req_t   req,
  input  logic                    res_accept,
  output logic                    clear,
  output logic                    step_done,
  output logic                    done,
  output logic                    busy
);

  import lstm_pkg::*;

  localparam neuron_idx_t LAST_NEURON = neuron_idx_t'(`LSTM_NEURONS - 1);

  typedef enum logic {
    ST_IDLE,
    ST_STEP
  } state_t;

  state_t      state;
  step_addr_t  step_addr;
  neuron_idx_t issue_idx;
  neuron_idx_t res_cnt;
  logic        all_issued;
  logic        rd_wait; // ram output not yet valid for the new index

  assign busy       = (state == ST_STEP);
  assign clear      = start & ~busy;
  assign x_addr     = step_addr;
  assign param_addr = issue_idx;
  assign req_valid  = busy & ~all_issued & ~rd_wait;

  assign req = '{neuron: issue_idx, step: step_addr, x: x, params: params,
                 c_prev: c_prev, h_prev: h_prev};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_IDLE;
      step_addr  <= '0;
      issue_idx  <= '0;
      res_cnt    <= '0;
      all_issued <= 1'b0;
      rd_wait    <= 1'b0;
      step_done  <= 1'b0;
      done       <= 1'b0;
    end else begin
      step_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state      <= ST_STEP;
            step_addr  <= start_addr;
            issue_idx  <= '0;
            res_cnt    <= '0;
            all_issued <= 1'b0;
            rd_wait    <= 1'b1;
            done       <= 1'b0;
          end
        end
        ST_STEP: begin
          rd_wait <= 1'b0;
          if (req_valid && req_ready) begin
            if (issue_idx == LAST_NEURON) begin
              all_issued <= 1'b1;
            end else begin
              issue_idx <= issue_idx + 1'b1;
              rd_wait   <= 1'b1;
            end
          end
          if (res_accept) begin
            if (res_cnt == LAST_NEURON) begin // step fully drained
              step_done <= 1'b1;
              res_cnt   <= '0;
              if (step_addr == end_addr) begin
                done  <= 1'b1;
                state <= ST_IDLE;
              end else begin
                step_addr  <= step_addr + 1'b1;
                issue_idx  <= '0;
                all_issued <= 1'b0;
                rd_wait    <= 1'b1;
              end
            end else begin
              res_cnt <= res_cnt + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  a_start_range: assert property (@(posedge clk) disable iff (!arst_n)
    (start && !busy) |-> (start_addr <= end_addr));

  a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (req_valid && !req_ready) |=> (req_valid && $stable(req)));

endmodule

`default_nettype wire

//--- logic/state_file.sv
/*
  Cell and hidden state per neuron, carried from one step to the next.
  Combinational read by neuron index, write on each accepted result.
*/
`timescale 1ns/1ps
`default_nettype none
`include "lstm_config.svh"

module state_file (
  input  wire                       clk,
  input  wire                       arst_n,
  input  logic                      clear,
  input  lstm_pkg::neuron_idx_t     rd_neuron,
  output lstm_pkg::data_t           c_prev,
  output lstm_pkg::data_t           h_prev,
  input  logic                      wr_en,
  input  lstm_pkg::neuron_result_t  wr
);

  import lstm_pkg::*;

  data_t c_mem [`LSTM_NEURONS];
  data_t h_mem [`LSTM_NEURONS];

  assign c_prev = c_mem[rd_neuron];
  assign h_prev = h_mem[rd_neuron];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      c_mem <= '{default: '0};
      h_mem <= '{default: '0};
    end else if (clear) begin // fresh sequence starts from zero state
      c_mem <= '{default: '0};
      h_mem <= '{default: '0};
    end else if (wr_en) begin
      c_mem[wr.neuron] <= wr.c_new;
      h_mem[wr.neuron] <= wr.h;
    end
  end

endmodule

`default_nettype wire

//--- logic/gate_datapath.sv
/*
  Three-stage LSTM cell pipeline: pre-activations, gates and cell update, then h.
  Each stage holds while the next one is full and stalled; three results in flight.
*/
`timescale 1ns/1ps
`default_nettype none
`include "lstm_config.svh"

module gate_datapath (
  input  wire                       clk,
  input  wire                       arst_n,
  input  logic                      req_valid,
  output logic                      req_ready,
  input  lstm_pkg::neuron_req_t     req,
  output logic                      res_valid,
  input  logic                      res_ready,
  output lstm_pkg::neuron_result_t  res
);

  import lstm_pkg::*;

  typedef logic signed [2*`LSTM_DATA_WIDTH-1:0] wide_t;

  localparam wide_t D_MAX = wide_t'(2**(`LSTM_DATA_WIDTH-1) - 1);
  localparam wide_t D_MIN = -D_MAX - wide_t'(1);
  localparam wide_t ONE   = wide_t'(1 << `LSTM_FRAC_BITS); // 1.0
  localparam wide_t HALF  = ONE >>> 1;

  ////////////////////
  // fixed point helpers
  ////////////////////

  function automatic data_t saturate(wide_t v);
    if (v > D_MAX) return data_t'(D_MAX);
    if (v < D_MIN) return data_t'(D_MIN);
    return data_t'(v);
  endfunction

  function automatic data_t sat_mul(data_t a, data_t b);
    wide_t prod;
    prod = wide_t'(a) * wide_t'(b);
    prod = prod >>> `LSTM_FRAC_BITS; // back to Q4.4
    return saturate(prod);
  endfunction

  function automatic data_t hard_sigmoid(data_t v);
    wide_t t;
    t = (wide_t'(v) >>> 2) + HALF;
    if (t < 0) return '0;
    if (t > ONE) return data_t'(ONE);
    return data_t'(t);
  endfunction

  function automatic data_t hard_tanh(data_t v);
    if (wide_t'(v) > ONE) return data_t'(ONE);
    if (wide_t'(v) < -ONE) return data_t'(-ONE);
    return v;
  endfunction

  function automatic data_t preact(gate_weights_t w, data_t x, data_t h);
    wide_t sum;
    sum = wide_t'(sat_mul(w.wx, x)) + wide_t'(sat_mul(w.uh, h)) + wide_t'(w.bias);
    return saturate(sum);
  endfunction

  ////////////////////
  // stage registers
  ////////////////////

  typedef struct packed {
    neuron_idx_t neuron;
    step_addr_t  step;
    data_t       c_prev;
    data_t       pre_i;
    data_t       pre_f;
    data_t       pre_o;
    data_t       pre_g;
  } s1_t;

  typedef struct packed {
    neuron_idx_t neuron;
    step_addr_t  step;
    data_t       c_new;
    data_t       o;
  } s2_t;

  s1_t            s1;
  s2_t            s2;
  neuron_result_t s3;
  logic           v1, v2, v3;
  logic           adv1, adv2, adv3;
  data_t          g_i, g_f, g_o, g_g;
  data_t          c_new;

  // a stage moves when empty or when the one after it moves
  assign adv3      = ~v3 | res_ready;
  assign adv2      = ~v2 | adv3;
  assign adv1      = ~v1 | adv2;
  assign req_ready = adv1;
  assign res_valid = v3;
  assign res       = s3;

  assign g_i   = hard_sigmoid(s1.pre_i);
  assign g_f   = hard_sigmoid(s1.pre_f);
  assign g_o   = hard_sigmoid(s1.pre_o);
  assign g_g   = hard_tanh(s1.pre_g);
  assign c_new = saturate(wide_t'(sat_mul(g_f, s1.c_prev)) + wide_t'(sat_mul(g_i, g_g)));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
      v3 <= 1'b0;
    end else begin
      if (adv1) v1 <= req_valid;
      if (adv2) v2 <= v1;
      if (adv3) v3 <= v2;
    end
  end

  always_ff @(posedge clk) begin
    if (adv1) begin
      s1.neuron <= req.neuron;
      s1.step   <= req.step;
      s1.c_prev <= req.c_prev;
      s1.pre_i  <= preact(req.params.gate_i, req.x, req.h_prev);
      s1.pre_f  <= preact(req.params.gate_f, req.x, req.h_prev);
      s1.pre_o  <= preact(req.params.gate_o, req.x, req.h_prev);
      s1.pre_g  <= preact(req.params.gate_g, req.x, req.h_prev);
    end
    if (adv2) begin
      s2 <= '{neuron: s1.neuron, step: s1.step, c_new: c_new, o: g_o};
    end
    if (adv3) begin
      s3.neuron <= s2.neuron;
      s3.step   <= s2.step;
      s3.c_new  <= s2.c_new;
      s3.h      <= sat_mul(s2.o, hard_tanh(s2.c_new));
    end
  end

  a_res_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (res_valid && !res_ready) |=> (res_valid && $stable(res)));

endmodule

`default_nettype wire

//--- logic/lstm_top.sv
/*
  LSTM cell engine top: x and parameter RAMs, sequencer, state file and gate pipeline.
  Load the RAMs while idle, pulse start, then collect h on the output stream.
*/
`timescale 1ns/1ps
`default_nettype none
`include "lstm_config.svh"

module lstm_top (
  input  wire                     clk,
  input  wire                     arst_n,
  input  logic                    start,
  input  lstm_pkg::step_addr_t    start_addr,
  input  lstm_pkg::step_addr_t    end_addr,
  input  lstm_pkg::x_write_t      x_wr,
  input  lstm_pkg::param_write_t  param_wr,
  output logic                    h_out_valid,
  input  logic                    h_out_ready,
  output lstm_pkg::h_out_t        h_out,
  output logic                    step_done,
  output logic                    done,
  output logic                    busy
);

  import lstm_pkg::*;

  step_addr_t     x_addr;
  neuron_idx_t    param_addr;
  data_t          x_word;
  neuron_params_t params;
  data_t          c_prev;
  data_t          h_prev;
  logic           req_valid;
  logic           req_ready;
  neuron_req_t    req;
  logic           res_valid;
  neuron_result_t res;
  logic           res_accept;
  logic           clear;

  assign res_accept  = res_valid & h_out_ready;
  assign h_out_valid = res_valid;
  assign h_out       = '{step: res.step, neuron: res.neuron, h: res.h};

  sync_ram #(.payload_t(data_t), .DEPTH(`LSTM_X_DEPTH)) x_ram_i (
    .clk(clk), .we(x_wr.en), .waddr(x_wr.addr), .wdata(x_wr.data),
    .raddr(x_addr), .rdata(x_word)
  );

  sync_ram #(.payload_t(neuron_params_t), .DEPTH(`LSTM_NEURONS)) param_ram_i (
    .clk(clk), .we(param_wr.en), .waddr(param_wr.neuron), .wdata(param_wr.params),
    .raddr(param_addr), .rdata(params)
  );

  step_sequencer step_sequencer_i (
    .clk(clk), .arst_n(arst_n), .start(start), .start_addr(start_addr),
    .end_addr(end_addr), .x_addr(x_addr), .param_addr(param_addr), .x(x_word),
    .params(params), .c_prev(c_prev), .h_prev(h_prev), .req_valid(req_valid),
    .req_ready(req_ready), .req(req), .res_accept(res_accept), .clear(clear),
    .step_done(step_done), .done(done), .busy(busy)
  );

  state_file state_file_i (
    .clk(clk), .arst_n(arst_n), .clear(clear), .rd_neuron(param_addr),
    .c_prev(c_prev), .h_prev(h_prev), .wr_en(res_accept), .wr(res)
  );

  gate_datapath gate_datapath_i (
    .clk(clk), .arst_n(arst_n), .req_valid(req_valid), .req_ready(req_ready),
    .req(req), .res_valid(res_valid), .res_ready(h_out_ready), .res(res)
  );

  // ram contents must not change under a running sequence
  a_no_load_busy: assert property (@(posedge clk) disable iff (!arst_n)
    busy |-> !(x_wr.en || param_wr.en));

endmodule

`default_nettype wire

//--- bench/lstm_tb.sv
/*
  Testbench for the LSTM cell engine: loads x words and weights, runs sequences and
  predicts every h from a fixed point model. Concurrent assertions do the checking.
*/
`timescale 1ns/1ps
`default_nettype none
`include "lstm_config.svh"

module lstm_tb;

  import lstm_pkg::*;

  localparam int N          = `LSTM_NEURONS;
  localparam int X_DEPTH    = `LSTM_X_DEPTH;
  localparam int DONE_LIMIT = 4000; // cycles per sequence

  logic         clk;
  logic         arst_n;
  logic         start;
  step_addr_t   start_addr;
  step_addr_t   end_addr;
  x_write_t     x_wr;
  param_write_t param_wr;
  logic         h_out_valid;
  logic         h_out_ready = 1'b1;
  h_out_t       h_out;
  logic         step_done;
  logic         done;
  logic         busy;

  int         seed;
  logic       started;
  logic       ready_random;
  int         wx_t[];
  int         uh_t[];
  int         bias_t[];
  int         x_vals[];
  int         c_model[];
  int         h_model[];
  h_out_t     exp_arr [256];
  h_out_t     exp_head;
  h_out_t     h_out_last;
  logic [7:0] exp_cnt;
  logic [7:0] got_cnt;
  int         exp_pulses;
  int         step_pulses;

  lstm_top lstm_top_i (
    .clk(clk), .arst_n(arst_n), .start(start), .start_addr(start_addr),
    .end_addr(end_addr), .x_wr(x_wr), .param_wr(param_wr), .h_out_valid(h_out_valid),
    .h_out_ready(h_out_ready), .h_out(h_out), .step_done(step_done), .done(done),
    .busy(busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic int sat_byte(input int v);
    if (v > 127) return 127;
    if (v < -128) return -128;
    return v;
  endfunction

  function automatic int scale_mul(input int a, input int b);
    return sat_byte((a * b) >>> 4);
  endfunction

  function automatic int sigmoid_approx(input int v);
    int t;
    t = (v >>> 2) + 8;
    if (t < 0) return 0;
    if (t > 16) return 16;
    return t;
  endfunction

  function automatic int tanh_clip(input int v);
    if (v > 16) return 16;
    if (v < -16) return -16;
    return v;
  endfunction

  // gate order i, f, o, g
  function automatic int gate_preact(input int n, input int gate, input int xv, input int hp);
    int k;
    k = n * 4 + gate;
    return sat_byte(scale_mul(wx_t[k], xv) + scale_mul(uh_t[k], hp) + bias_t[k]);
  endfunction

  function automatic gate_weights_t pack_gate(input int n, input int gate);
    int k;
    k = n * 4 + gate;
    return '{wx: data_t'(wx_t[k]), uh: data_t'(uh_t[k]), bias: data_t'(bias_t[k])};
  endfunction

  // expected h stream of one sequence, starting from zero state
  task automatic predict_run(input int first, input int last);
    int ig, fg, og, gg, cn;
    for (int n = 0; n < N; n++) begin
      c_model[n] = 0;
      h_model[n] = 0;
    end
    for (int s = first; s <= last; s++) begin
      for (int n = 0; n < N; n++) begin
        ig = sigmoid_approx(gate_preact(n, 0, x_vals[s], h_model[n]));
        fg = sigmoid_approx(gate_preact(n, 1, x_vals[s], h_model[n]));
        og = sigmoid_approx(gate_preact(n, 2, x_vals[s], h_model[n]));
        gg = tanh_clip(gate_preact(n, 3, x_vals[s], h_model[n]));
        cn = sat_byte(scale_mul(fg, c_model[n]) + scale_mul(ig, gg));
        c_model[n] = cn;
        h_model[n] = scale_mul(og, tanh_clip(cn));
        exp_arr[exp_cnt] = '{step: step_addr_t'(s), neuron: neuron_idx_t'(n),
                             h: data_t'(h_model[n])};
        exp_cnt = exp_cnt + 8'd1;
      end
    end
    exp_pulses = exp_pulses + (last - first + 1);
  endtask

  ////////////////////
  // stimulus helpers
  ////////////////////

  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic draw_values();
    wx_t   = new[N * 4];
    uh_t   = new[N * 4];
    bias_t = new[N * 4];
    x_vals = new[X_DEPTH];
    for (int k = 0; k < N * 4; k++) begin
      wx_t[k]   = $random(seed) % 48;
      uh_t[k]   = $random(seed) % 48;
      if (uh_t[k] == 0) uh_t[k] = 7; // keep every recurrence live
      bias_t[k] = $random(seed) % 32;
    end
    for (int a = 0; a < X_DEPTH; a++) begin
      x_vals[a] = $random(seed) % 128;
    end
  endtask

  task automatic load_memories();
    for (int a = 0; a < X_DEPTH; a++) begin
      @(posedge clk);
      x_wr <= '{en: 1'b1, addr: step_addr_t'(a), data: data_t'(x_vals[a])};
    end
    @(posedge clk);
    x_wr <= '0;
    for (int n = 0; n < N; n++) begin
      @(posedge clk);
      param_wr <= '{en: 1'b1, neuron: neuron_idx_t'(n),
                    params: '{gate_i: pack_gate(n, 0), gate_f: pack_gate(n, 1),
                              gate_o: pack_gate(n, 2), gate_g: pack_gate(n, 3)}};
    end
    @(posedge clk);
    param_wr <= '0;
    @(posedge clk);
  endtask

  task automatic run_sequence(input int first, input int last);
    int cycles;
    predict_run(first, last);
    @(posedge clk);
    start_addr <= step_addr_t'(first);
    end_addr   <= step_addr_t'(last);
    start      <= 1'b1;
    started    <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk); // old done has dropped by now
    cycles = 0;
    while (!done && cycles < DONE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      $display("timeout: done did not rise within %0d cycles for steps %0d..%0d",
               DONE_LIMIT, first, last);
      stop_with_failure();
    end else begin
      repeat (3) @(posedge clk);
    end
  endtask

  ////////////////////
  // output side
  ////////////////////

  always @(posedge clk) begin : ready_gen
    int draw;
    if (ready_random) begin
      draw = $random(seed);
      h_out_ready <= draw[0];
    end else begin
      h_out_ready <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      got_cnt     <= '0;
      step_pulses <= 0;
    end else begin
      if (h_out_valid && h_out_ready) got_cnt <= got_cnt + 8'd1;
      if (step_done) step_pulses <= step_pulses + 1;
    end
  end

  always_ff @(posedge clk) h_out_last <= h_out;

  always_comb exp_head = exp_arr[got_cnt];

  ////////////////////
  // checks
  ////////////////////

  quiet_before_start: assert property (@(posedge clk) disable iff (!arst_n)
    !started |-> !(h_out_valid || step_done || done || busy))
    else begin
      $display("outputs active before the first start at %0t", $time);
      stop_with_failure();
    end

  h_matches_model: assert property (@(posedge clk) disable iff (!arst_n)
    (h_out_valid && h_out_ready) |-> (h_out == exp_head))
    else begin
      $display("CHECK FAILED at %0t: h_out = %h, expected %h", $time,
               $sampled(h_out), $sampled(exp_head));
      stop_with_failure();
    end

  no_extra_output: assert property (@(posedge clk) disable iff (!arst_n)
    (h_out_valid && h_out_ready) |-> (got_cnt < exp_cnt))
    else begin
      $display("an output was accepted that the model does not expect, at %0t", $time);
      stop_with_failure();
    end

  valid_held: assert property (@(posedge clk) disable iff (!arst_n)
    (h_out_valid && !h_out_ready) |=> h_out_valid)
    else begin
      $display("h_out_valid dropped while the output was stalled, at %0t", $time);
      stop_with_failure();
    end

  h_out_held: assert property (@(posedge clk) disable iff (!arst_n)
    (h_out_valid && !h_out_ready) |=> (h_out == h_out_last))
    else begin
      $display("CHECK FAILED at %0t: h_out = %h, expected %h", $time,
               $sampled(h_out), $sampled(h_out_last));
      stop_with_failure();
    end

  all_outputs_in: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(done) |-> (got_cnt == exp_cnt))
    else begin
      $display("CHECK FAILED at %0t: got_cnt = %0d, expected %0d", $time,
               $sampled(got_cnt), $sampled(exp_cnt));
      stop_with_failure();
    end

  done_with_last_step: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(done) |-> step_done)
    else begin
      $display("done rose without a step_done pulse, at %0t", $time);
      stop_with_failure();
    end

  pulse_count: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(done) |=> (step_pulses == exp_pulses))
    else begin
      $display("CHECK FAILED at %0t: step_pulses = %0d, expected %0d", $time,
               $sampled(step_pulses), $sampled(exp_pulses));
      stop_with_failure();
    end

  done_holds: assert property (@(posedge clk) disable iff (!arst_n)
    (done && !start) |=> done)
    else begin
      $display("done fell without a new start, at %0t", $time);
      stop_with_failure();
    end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    seed         = 32'hc097;
    arst_n       = 1'b0;
    start        = 1'b0;
    start_addr   = '0;
    end_addr     = '0;
    x_wr         = '0;
    param_wr     = '0;
    started      = 1'b0;
    ready_random = 1'b0;
    exp_cnt      = '0;
    exp_pulses   = 0;
    c_model      = new[N];
    h_model      = new[N];
    draw_values();
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    repeat (4) @(posedge clk); // idle window after reset
    load_memories();
    run_sequence(2, 2);        // single step, order and tags
    run_sequence(5, 8);        // recurrence over four steps
    ready_random <= 1'b1;
    run_sequence(40, 43);      // back-pressure on h_out
    ready_random <= 1'b0;
    run_sequence(20, 22);
    run_sequence(20, 22);      // restart must begin from zero state
    repeat (4) @(posedge clk);
    if (got_cnt == exp_cnt && step_pulses == exp_pulses) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("outputs %0d of %0d, step pulses %0d of %0d", got_cnt, exp_cnt,
               step_pulses, exp_pulses);
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
logic/lstm_pkg.sv
logic/sync_ram.sv
logic/step_sequencer.sv
logic/state_file.sv
logic/gate_datapath.sv
logic/lstm_top.sv
bench/lstm_tb.sv

//--- run.sh
#!/bin/sh
# build and run the LSTM engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module lstm_tb -f sources.f -o lstm_sim \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/lstm_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation finished: PASS" \
  && exit 0 \
  || exit 1
